/* verilog/blackbox_params.svh */
`ifndef BLACKBOX_PARAMS_SVH
`define BLACKBOX_PARAMS_SVH

// --------------------
// Sizes
`define BB_NR_IOS           8    // Board pins and virtual channels
`define BB_DATA_WIDTH       32   // Wishbone data word
`define BB_ADDR_WIDTH       3    // Wishbone word address
`define BB_FE_SEL_WIDTH     8
`define BB_PROC_CODE_WIDTH  4    // One mode code per channel

// --------------------
// Version, packed into the info word
`define BB_VERSION_MAJOR    1    // 12 bits
`define BB_VERSION_MINOR    2    // 4 bits

// --------------------
// Debounce lengths in samples
`define BB_SHORT_STAGES_A   2
`define BB_SHORT_STAGES_B   4
`define BB_LONG_TICKS       125

// --------------------
// Register word addresses
`define BB_REG_INFO         3'd0
`define BB_REG_STATUS       3'd1
`define BB_REG_PROC_SEL     3'd2
`define BB_REG_VIRT_OUT     3'd3
`define BB_REG_VIRT_DIR     3'd4
`define BB_REG_VIRT_IN      3'd5

`endif

/* verilog/blackbox_pkg.sv */
`include "blackbox_params.svh"

package blackbox_pkg;

	// --------------------
	// Frontend behavior after decoding the board code
	typedef enum logic [0:0]
	{
		fe_unknown,   // All pins inputs, read as zero
		fe_ocio       // Pins wired straight through
	} frontend_mode_t;

	// --------------------
	// Per-channel processing
	typedef enum logic [2:0]
	{
		pm_disable,
		pm_pass,
		pm_debounce_a,    // Short debounce, stages A
		pm_debounce_b,    // Short debounce, stages B
		pm_debounce_long  // Counter based
	} proc_mode_t;

	// Mode register, seen by the bus as one word and by the decoder as codes
	typedef union packed
	{
		logic [`BB_DATA_WIDTH-1:0] raw;
		logic [`BB_NR_IOS-1:0][`BB_PROC_CODE_WIDTH-1:0] code;
	} proc_sel_word_t;

endpackage

/* verilog/channel_proc.sv */
`include "blackbox_params.svh"

module channel_proc
	import blackbox_pkg::*;
(
	input  logic        clock,
	input  logic        arst_n,
	input  proc_mode_t  mode,
	input  logic        internal_in,
	input  logic        virtual_out,
	input  logic        virtual_dir,    // 1 = output
	output logic        internal_out,
	output logic        output_enable,
	output logic        virtual_in
);

	logic [`BB_SHORT_STAGES_B-2:0] hist;      // Past samples
	logic [`BB_SHORT_STAGES_B-1:0] window;    // Past samples plus current
	logic                          deb_q;     // Debounced level
	logic [6:0]                    stable_cnt;
	logic                          hold_a;
	logic                          hold_b;

	assign window = {hist, internal_in};

	// Window fully ones or fully zeros
	assign hold_a = (&window[`BB_SHORT_STAGES_A-1:0]) | ~(|window[`BB_SHORT_STAGES_A-1:0]);
	assign hold_b = (&window) | ~(|window);

	// --------------------
	// Debounce state
	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
		begin
			hist       <= '0;
			deb_q      <= 1'b0;
			stable_cnt <= '0;
		end
		else
		begin
			hist <= window[`BB_SHORT_STAGES_B-2:0];
			case (mode)
				pm_pass:
				begin
					deb_q      <= internal_in;  // Start debounce from current level
					stable_cnt <= '0;
				end
				pm_debounce_a:
				begin
					stable_cnt <= '0;
					if (hold_a)
						deb_q <= internal_in;
				end
				pm_debounce_b:
				begin
					stable_cnt <= '0;
					if (hold_b)
						deb_q <= internal_in;
				end
				pm_debounce_long:
				begin
					if (internal_in == deb_q)
						stable_cnt <= '0;  // Run broken
					else if (stable_cnt == 7'(`BB_LONG_TICKS - 1))
					begin
						deb_q      <= internal_in;
						stable_cnt <= '0;
					end
					else
						stable_cnt <= stable_cnt + 7'd1;
				end
				default:
				begin
					deb_q      <= 1'b0;
					stable_cnt <= '0;
				end
			endcase
		end
	end

	// --------------------
	// Outputs
	always_comb
	begin
		case (mode)
			pm_disable: virtual_in = 1'b0;
			pm_pass:    virtual_in = internal_in;
			default:    virtual_in = deb_q;
		endcase
	end

	assign internal_out  = virtual_out;
	assign output_enable = virtual_dir & (mode != pm_disable);

endmodule

/* verilog/frontend_port.sv */
`include "blackbox_params.svh"

module frontend_port
	import blackbox_pkg::*;
(
	input  logic                   clock,
	input  logic                   arst_n,
	input  frontend_mode_t         fe_mode,
	input  logic [`BB_NR_IOS-1:0]  diob_in,
	input  logic [`BB_NR_IOS-1:0]  internal_out,
	input  logic [`BB_NR_IOS-1:0]  output_enable,
	output logic [`BB_NR_IOS-1:0]  diob_out,
	output logic [`BB_NR_IOS-1:0]  diob_dir,
	output logic [`BB_NR_IOS-1:0]  internal_in
);

	logic [`BB_NR_IOS-1:0] sync_1;
	logic [`BB_NR_IOS-1:0] sync_2;

	// --------------------
	// Two-flop pin synchronizer
	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
		begin
			sync_1 <= '0;
			sync_2 <= '0;
		end
		else
		begin
			sync_1 <= diob_in;  // May go metastable
			sync_2 <= sync_1;
		end
	end

	// --------------------
	// Routing by frontend behavior
	always_comb
	begin
		case (fe_mode)
			fe_ocio:
			begin
				internal_in = sync_2;
				diob_out    = internal_out;
				diob_dir    = output_enable;
			end
			default:
			begin
				// Unknown board, keep every pin as input
				internal_in = '0;
				diob_out    = '0;
				diob_dir    = '0;
			end
		endcase
	end

endmodule

/* verilog/blackbox_regs.sv */
`include "blackbox_params.svh"

module blackbox_regs
	import blackbox_pkg::*;
(
	input  logic                         clock,
	input  logic                         arst_n,
	input  logic [`BB_FE_SEL_WIDTH-1:0]  frontend_plugin_select,
	input  logic [`BB_NR_IOS-1:0]        virtual_in,

	input  logic                         wb_cyc,
	input  logic                         wb_stb,
	input  logic                         wb_we,
	input  logic [`BB_ADDR_WIDTH-1:0]    wb_adr,
	input  logic [`BB_DATA_WIDTH-1:0]    wb_dat_w,
	output logic [`BB_DATA_WIDTH-1:0]    wb_dat_r,
	output logic                         wb_ack,

	output frontend_mode_t               fe_mode,
	output proc_mode_t [`BB_NR_IOS-1:0]  chan_mode,
	output logic [`BB_NR_IOS-1:0]        virtual_out,
	output logic [`BB_NR_IOS-1:0]        virtual_dir
);

	proc_sel_word_t               proc_sel;
	logic                         fe_default;
	logic [`BB_NR_IOS-1:0]        chan_default;
	logic                         bus_access;
	logic                         bus_write;
	logic [`BB_DATA_WIDTH-1:0]    info_word;
	logic [`BB_DATA_WIDTH-1:0]    status_word;
	logic [`BB_DATA_WIDTH-1:0]    rd_word;

	// --------------------
	// Selection code decoding
	always_comb
	begin
		case (frontend_plugin_select)
			8'd4, 8'd14:   // Both ocio board variants
			begin
				fe_mode    = fe_ocio;
				fe_default = 1'b0;
			end
			8'd255:        // Explicitly unknown
			begin
				fe_mode    = fe_unknown;
				fe_default = 1'b0;
			end
			default:
			begin
				fe_mode    = fe_unknown;
				fe_default = 1'b1;
			end
		endcase
	end

	always_comb
	begin
		for (int i = 0; i < `BB_NR_IOS; i++)
		begin
			chan_default[i] = 1'b0;
			case (proc_sel.code[i])
				4'd0:    chan_mode[i] = pm_disable;
				4'd1:    chan_mode[i] = pm_pass;
				4'd2:    chan_mode[i] = pm_debounce_a;
				4'd3:    chan_mode[i] = pm_debounce_b;
				4'd4:    chan_mode[i] = pm_debounce_long;
				default:
				begin
					chan_mode[i]    = pm_disable;  // Unknown code falls back
					chan_default[i] = 1'b1;
				end
			endcase
		end
	end

	// --------------------
	// Read-only words
	assign info_word = {16'd0, 12'(`BB_VERSION_MAJOR), 4'(`BB_VERSION_MINOR)};
	assign status_word = {16'd0, frontend_plugin_select, 5'd0,
		fe_mode == fe_ocio, |chan_default, fe_default};

	always_comb
	begin
		case (wb_adr)
			`BB_REG_INFO:     rd_word = info_word;
			`BB_REG_STATUS:   rd_word = status_word;
			`BB_REG_PROC_SEL: rd_word = proc_sel.raw;
			`BB_REG_VIRT_OUT: rd_word = `BB_DATA_WIDTH'(virtual_out);
			`BB_REG_VIRT_DIR: rd_word = `BB_DATA_WIDTH'(virtual_dir);
			`BB_REG_VIRT_IN:  rd_word = `BB_DATA_WIDTH'(virtual_in);
			default:          rd_word = '0;  // Holes read zero
		endcase
	end

	// --------------------
	// Wishbone slave, one cycle from stb to ack
	assign bus_access = wb_cyc & wb_stb & ~wb_ack;
	assign bus_write  = bus_access & wb_we;

	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
			wb_ack <= 1'b0;
		else
			wb_ack <= bus_access;  // Single pulse per access
	end

	always_ff @(posedge clock)
	begin
		if (bus_access)
			wb_dat_r <= rd_word;
	end

	// Writable registers, taken at the ack edge
	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
		begin
			proc_sel.raw <= '0;
			virtual_out  <= '0;
			virtual_dir  <= '0;
		end
		else if (bus_write)
		begin
			case (wb_adr)
				`BB_REG_PROC_SEL: proc_sel.raw <= wb_dat_w;
				`BB_REG_VIRT_OUT: virtual_out  <= wb_dat_w[`BB_NR_IOS-1:0];
				`BB_REG_VIRT_DIR: virtual_dir  <= wb_dat_w[`BB_NR_IOS-1:0];
				default:          ;  // Read-only or unused
			endcase
		end
	end

endmodule

/* verilog/io_blackbox.sv */
`include "blackbox_params.svh"

module io_blackbox
	import blackbox_pkg::*;
(
	input  logic                         clock,
	input  logic                         arst_n,
	input  logic [`BB_FE_SEL_WIDTH-1:0]  frontend_plugin_select,  // Static board code

	// Board pins, split for the pad ring
	input  logic [`BB_NR_IOS-1:0]        diob_in,
	output logic [`BB_NR_IOS-1:0]        diob_out,
	output logic [`BB_NR_IOS-1:0]        diob_dir,   // 1 = pin drives

	// Wishbone classic slave
	input  logic                         wb_cyc,
	input  logic                         wb_stb,
	input  logic                         wb_we,
	input  logic [`BB_ADDR_WIDTH-1:0]    wb_adr,
	input  logic [`BB_DATA_WIDTH-1:0]    wb_dat_w,
	output logic [`BB_DATA_WIDTH-1:0]    wb_dat_r,
	output logic                         wb_ack
);

	frontend_mode_t                    fe_mode;
	proc_mode_t [`BB_NR_IOS-1:0]       chan_mode;
	logic [`BB_NR_IOS-1:0]             virtual_out;
	logic [`BB_NR_IOS-1:0]             virtual_dir;
	logic [`BB_NR_IOS-1:0]             virtual_in;
	logic [`BB_NR_IOS-1:0]             internal_in;
	logic [`BB_NR_IOS-1:0]             internal_out;
	logic [`BB_NR_IOS-1:0]             output_enable;

	// --------------------
	// Control and register file
	blackbox_regs u_blackbox_regs (
		.clock                  (clock),
		.arst_n                 (arst_n),
		.frontend_plugin_select (frontend_plugin_select),
		.virtual_in             (virtual_in),
		.wb_cyc                 (wb_cyc),
		.wb_stb                 (wb_stb),
		.wb_we                  (wb_we),
		.wb_adr                 (wb_adr),
		.wb_dat_w               (wb_dat_w),
		.wb_dat_r               (wb_dat_r),
		.wb_ack                 (wb_ack),
		.fe_mode                (fe_mode),
		.chan_mode              (chan_mode),
		.virtual_out            (virtual_out),
		.virtual_dir            (virtual_dir)
	);

	// --------------------
	// Pins to channels
	frontend_port u_frontend_port (
		.clock         (clock),
		.arst_n        (arst_n),
		.fe_mode       (fe_mode),
		.diob_in       (diob_in),
		.internal_out  (internal_out),
		.output_enable (output_enable),
		.diob_out      (diob_out),
		.diob_dir      (diob_dir),
		.internal_in   (internal_in)
	);

	// --------------------
	// One processor per virtual channel
	for (genvar i = 0; i < `BB_NR_IOS; i++)
	begin : gen_chan
		channel_proc u_channel_proc (
			.clock         (clock),
			.arst_n        (arst_n),
			.mode          (chan_mode[i]),
			.internal_in   (internal_in[i]),
			.virtual_out   (virtual_out[i]),
			.virtual_dir   (virtual_dir[i]),
			.internal_out  (internal_out[i]),
			.output_enable (output_enable[i]),
			.virtual_in    (virtual_in[i])
		);
	end

endmodule

/* test/tb_bus_tasks.svh */
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

// --------------------
// Wishbone master, driven on the falling edge

localparam int ACK_TIMEOUT = 16;  // Cycles allowed from stb to ack

task automatic wait_for_ack(input logic [`BB_ADDR_WIDTH-1:0] adr);
	int cycles;
	cycles = 0;
	do
	begin
		@(negedge clock);
		cycles++;
	end
	while (!wb_ack && cycles < ACK_TIMEOUT);
	if (!wb_ack)
	begin
		$display("Timeout: no Wishbone ack from address %0d after %0d cycles", adr, cycles);
		timeout_count++;
	end
endtask

// Master lets go after seeing ack, so ack must be gone one cycle later
task automatic end_access();
	wb_cyc = 1'b0;
	wb_stb = 1'b0;
	wb_we  = 1'b0;
	@(negedge clock);
	compare_word("ack after one cycle", `BB_DATA_WIDTH'(wb_ack), '0);
endtask

task automatic bus_write(input logic [`BB_ADDR_WIDTH-1:0] adr,
	input logic [`BB_DATA_WIDTH-1:0] data);
	wb_cyc   = 1'b1;
	wb_stb   = 1'b1;
	wb_we    = 1'b1;
	wb_adr   = adr;
	wb_dat_w = data;
	wait_for_ack(adr);
	end_access();
endtask

task automatic bus_read(input logic [`BB_ADDR_WIDTH-1:0] adr,
	output logic [`BB_DATA_WIDTH-1:0] data);
	wb_cyc = 1'b1;
	wb_stb = 1'b1;
	wb_we  = 1'b0;
	wb_adr = adr;
	wait_for_ack(adr);
	data = wb_dat_r;  // Valid while ack is high
	end_access();
endtask

// Reads virtual_in until it matches or the read budget runs out
task automatic poll_virtual_in(input logic [`BB_NR_IOS-1:0] expected, input int max_reads);
	logic [`BB_DATA_WIDTH-1:0] data;
	int reads;
	reads = 0;
	do
	begin
		bus_read(`BB_REG_VIRT_IN, data);
		reads++;
	end
	while (data !== `BB_DATA_WIDTH'(expected) && reads < max_reads);
	if (data !== `BB_DATA_WIDTH'(expected))
	begin
		$display("Timeout: virtual_in did not reach %h within %0d reads", expected, max_reads);
		timeout_count++;
	end
endtask

`endif

/* test/tb_io_blackbox.sv */
`include "blackbox_params.svh"

module tb_io_blackbox;

	logic                         clock;
	logic                         arst_n;
	logic [`BB_FE_SEL_WIDTH-1:0]  frontend_plugin_select;
	logic [`BB_NR_IOS-1:0]        diob_in;
	logic [`BB_NR_IOS-1:0]        diob_out;
	logic [`BB_NR_IOS-1:0]        diob_dir;
	logic                         wb_cyc;
	logic                         wb_stb;
	logic                         wb_we;
	logic [`BB_ADDR_WIDTH-1:0]    wb_adr;
	logic [`BB_DATA_WIDTH-1:0]    wb_dat_w;
	logic [`BB_DATA_WIDTH-1:0]    wb_dat_r;
	logic                         wb_ack;

	int check_count;
	int error_count;
	int timeout_count;

	io_blackbox u_io_blackbox (
		.clock                  (clock),
		.arst_n                 (arst_n),
		.frontend_plugin_select (frontend_plugin_select),
		.diob_in                (diob_in),
		.diob_out               (diob_out),
		.diob_dir               (diob_dir),
		.wb_cyc                 (wb_cyc),
		.wb_stb                 (wb_stb),
		.wb_we                  (wb_we),
		.wb_adr                 (wb_adr),
		.wb_dat_w               (wb_dat_w),
		.wb_dat_r               (wb_dat_r),
		.wb_ack                 (wb_ack)
	);

	initial
	begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	task automatic compare_word(input string what, input logic [`BB_DATA_WIDTH-1:0] got,
		input logic [`BB_DATA_WIDTH-1:0] expected);
		check_count++;
		assert (got === expected) else
		begin
			$display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, expected);
			error_count++;
		end
	endtask

	// Status word as the register map defines it
	function automatic logic [`BB_DATA_WIDTH-1:0] status_for_code(
		input logic [`BB_FE_SEL_WIDTH-1:0] code, input logic chan_fallback);
		logic ocio;
		logic known;
		ocio  = (code == 8'd4) || (code == 8'd14);
		known = ocio || (code == 8'd255);
		return {16'd0, code, 5'd0, ocio, chan_fallback, ~known};
	endfunction

	function automatic logic [`BB_DATA_WIDTH-1:0] all_channels(input logic [3:0] code);
		return {`BB_NR_IOS{code}};
	endfunction

	`include "tb_bus_tasks.svh"

	initial
	begin
		logic [`BB_FE_SEL_WIDTH-1:0] fe_codes [4];
		logic [`BB_DATA_WIDTH-1:0]   data;
		logic [`BB_NR_IOS-1:0]       out_pattern;
		logic [`BB_NR_IOS-1:0]       dir_pattern;
		logic [`BB_NR_IOS-1:0]       in_pattern;
		logic [`BB_NR_IOS-1:0]       deb_pattern;
		int                          k;

		arst_n                 = 1'b0;
		frontend_plugin_select = 8'd4;
		diob_in                = '0;
		wb_cyc                 = 1'b0;
		wb_stb                 = 1'b0;
		wb_we                  = 1'b0;
		wb_adr                 = '0;
		wb_dat_w               = '0;
		void'($urandom(32'h8db9_e08c));
		fe_codes = '{8'd4, 8'd14, 8'd255, 8'd7};

		// --------------------
		// Reset and info
		repeat (16) @(negedge clock);
		arst_n = 1'b1;
		@(negedge clock);
		compare_word("diob_dir after reset", `BB_DATA_WIDTH'(diob_dir), '0);
		bus_read(`BB_REG_INFO, data);
		compare_word("info word", data,
			`BB_DATA_WIDTH'((`BB_VERSION_MAJOR << 4) | `BB_VERSION_MINOR));

		// --------------------
		// Frontend decode ending on the unknown code 7
		for (k = 0; k < 4; k++)
		begin
			frontend_plugin_select = fe_codes[k];
			@(negedge clock);
			bus_read(`BB_REG_STATUS, data);
			compare_word("status word", data, status_for_code(fe_codes[k], 1'b0));
		end
		bus_write(`BB_REG_PROC_SEL, all_channels(4'd1));
		bus_write(`BB_REG_VIRT_DIR, '1);
		compare_word("diob_dir in unknown mode", `BB_DATA_WIDTH'(diob_dir), '0);

		// --------------------
		// Output pass in ocio mode
		frontend_plugin_select = 8'd4;
		out_pattern = (`BB_NR_IOS'($urandom) & 8'hfc) | 8'h01;  // Pin 0 drives 1, pin 1 drives 0
		dir_pattern = `BB_NR_IOS'($urandom) | 8'h03;
		bus_write(`BB_REG_VIRT_OUT, `BB_DATA_WIDTH'(out_pattern));
		bus_write(`BB_REG_VIRT_DIR, `BB_DATA_WIDTH'(dir_pattern));
		compare_word("diob_dir", `BB_DATA_WIDTH'(diob_dir), `BB_DATA_WIDTH'(dir_pattern));
		compare_word("diob_out on driving pins", `BB_DATA_WIDTH'(diob_out & dir_pattern),
			`BB_DATA_WIDTH'(out_pattern & dir_pattern));
		bus_read(`BB_REG_VIRT_DIR, data);
		compare_word("virtual_dir readback", data, `BB_DATA_WIDTH'(dir_pattern));
		bus_write(`BB_REG_PROC_SEL, all_channels(4'd0));
		compare_word("diob_dir with channels disabled", `BB_DATA_WIDTH'(diob_dir), '0);

		// --------------------
		// Input pass, disable and an invalid code
		bus_write(`BB_REG_VIRT_DIR, '0);
		bus_write(`BB_REG_PROC_SEL, all_channels(4'd1));
		in_pattern = `BB_NR_IOS'($urandom) | 8'h81;  // Channels 0 and 7 high for the disable checks
		diob_in = in_pattern;
		poll_virtual_in(in_pattern, 8);
		bus_write(`BB_REG_PROC_SEL, 32'h0000_1111);  // Upper four channels off
		bus_read(`BB_REG_VIRT_IN, data);
		compare_word("virtual_in, upper half disabled", data,
			`BB_DATA_WIDTH'(in_pattern & 8'h0f));
		bus_write(`BB_REG_PROC_SEL, 32'h0000_1119);
		bus_read(`BB_REG_VIRT_IN, data);
		compare_word("virtual_in, code 9 on channel 0", data,
			`BB_DATA_WIDTH'(in_pattern & 8'h0e));
		bus_read(`BB_REG_STATUS, data);
		compare_word("status with channel fallback", data, status_for_code(8'd4, 1'b1));

		// --------------------
		// Four-sample debounce
		deb_pattern = `BB_NR_IOS'($urandom) | 8'h80;
		bus_write(`BB_REG_PROC_SEL, all_channels(4'd3));
		diob_in = '0;
		poll_virtual_in('0, 8);
		diob_in = deb_pattern;
		repeat (2) @(negedge clock);  // Short glitch
		diob_in = '0;
		for (k = 0; k < 6; k++)
		begin
			bus_read(`BB_REG_VIRT_IN, data);
			compare_word("virtual_in after 2-cycle pulse", data, '0);
		end
		diob_in = deb_pattern;
		repeat (10) @(negedge clock);
		bus_read(`BB_REG_VIRT_IN, data);
		compare_word("virtual_in after 10-cycle level", data, `BB_DATA_WIDTH'(deb_pattern));

		// --------------------
		// Long debounce
		diob_in = '0;
		poll_virtual_in('0, 8);
		bus_write(`BB_REG_PROC_SEL, all_channels(4'd4));
		diob_in = deb_pattern;
		repeat (60) @(negedge clock);
		bus_read(`BB_REG_VIRT_IN, data);
		compare_word("virtual_in after 60-cycle level", data, '0);
		diob_in = '0;
		repeat (4) @(negedge clock);  // Break the run
		diob_in = deb_pattern;
		repeat (200) @(negedge clock);
		bus_read(`BB_REG_VIRT_IN, data);
		compare_word("virtual_in after 200-cycle level", data, `BB_DATA_WIDTH'(deb_pattern));

		$display("Checks: %0d, errors: %0d, timeouts: %0d", check_count, error_count,
			timeout_count);
		if (error_count == 0 && timeout_count == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

/* list.f */
+incdir+verilog
+incdir+test
verilog/blackbox_pkg.sv
verilog/channel_proc.sv
verilog/frontend_port.sv
verilog/blackbox_regs.sv
verilog/io_blackbox.sv
test/tb_io_blackbox.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_io_blackbox -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -qF "=== PASS ===" sim.log
then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed"
	exit 1
fi
